/* hw/fma_add_stage.sv */
`include "fma_cfg.svh"

module fma_add_stage (
  input  logic clk,
  input  logic arst_n,
  input  logic in_valid,
  input  fma_pkg::fma_mul_t mul,
  output logic out_valid,
  output fma_pkg::fma_sum_t sum
);

  localparam int AW = 2 * `FMA_FRAC_W + 5;     // product plus three low bits
  localparam int SH_W = $clog2(AW);
  localparam int LZ_W = $clog2(AW + 1);

  fma_pkg::sexp_t add_expo;
  fma_pkg::sexp_t expo_diff;
  fma_pkg::sexp_t big_expo;
  logic [AW-1:0] prod_ext;
  logic [AW-1:0] addend_ext;
  logic [AW-1:0] big;
  logic [AW-1:0] small_op;
  logic [AW-1:0] small_sh;
  logic [AW-1:0] small_j;
  logic [SH_W-1:0] shamt;
  logic [AW:0] raw;
  logic [AW:0] mag;
  logic [AW:0] norm;
  logic [LZ_W-1:0] lz;
  logic prod_zero;
  logic add_zero;
  logic prod_big;
  logic lost;
  logic eff_sub;
  logic neg;
  fma_pkg::fma_sum_t next;

  always_comb begin
    add_expo = fma_pkg::sexp_t'({2'b00, mul.add_expo});
    // both binary points land on bit AW-2
    prod_ext = {mul.prod, 3'b000};
    addend_ext = {1'b0, mul.add_sig, {(AW - `FMA_FRAC_W - 2){1'b0}}};

    prod_zero = (mul.prod == '0);
    add_zero = (mul.add_sig == '0);
    prod_big = add_zero | (~prod_zero & (mul.prod_expo >= add_expo));

    big = prod_big ? prod_ext : addend_ext;
    small_op = prod_big ? addend_ext : prod_ext;
    big_expo = prod_big ? mul.prod_expo : add_expo;
    expo_diff = prod_big ? mul.prod_expo - add_expo : add_expo - mul.prod_expo;
    shamt = (expo_diff >= AW) ? SH_W'(AW) : expo_diff[SH_W-1:0];

    // align and fold the shifted out bits into the lsb
    small_sh = small_op >> shamt;
    lost = |(small_op & ~({AW{1'b1}} << shamt));
    small_j = {small_sh[AW-1:1], small_sh[0] | lost};

    eff_sub = mul.prod_sign ^ mul.add_sign;
    if (eff_sub) begin
      raw = {1'b0, big} - {1'b0, small_j};
    end else begin
      raw = {1'b0, big} + {1'b0, small_j};
    end
    neg = eff_sub & raw[AW];                    // big was smaller at equal exponents
    mag = neg ? -raw : raw;

    lz = '0;
    for (int i = 0; i <= AW; i++) begin
      if (mag[i]) begin
        lz = LZ_W'(AW - i);
      end
    end
    norm = mag << lz;

    next.id = mul.id;
    next.special = mul.special;
    next.zero = (mag == '0);
    if (next.zero) begin
      // exact cancellation is +0 under rne
      next.sign = prod_zero & add_zero & ~eff_sub & mul.prod_sign;
    end else begin
      next.sign = (neg ^ prod_big) ? mul.prod_sign : mul.add_sign;
    end
    next.expo = big_expo + fma_pkg::sexp_t'(2) - fma_pkg::sexp_t'(lz);
    next.sig = {norm[AW -: `FMA_FRAC_W + 3], |norm[AW - `FMA_FRAC_W - 3:0]};
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      sum <= next;
    end
  end

endmodule

/* hw/fma_cfg.svh */
`ifndef FMA_CFG_SVH
`define FMA_CFG_SVH

// single precision operand format
`define FMA_EXPO_W 8
`define FMA_FRAC_W 23
`define FMA_FLEN 32

`define FMA_ID_W 3

// result entries and issue credits
`define FMA_WB_DEPTH 4

`define FMA_CANON_NAN 32'h7fc00000

`endif

/* hw/fma_mul_stage.sv */
`include "fma_cfg.svh"

module fma_mul_stage (
  input  logic clk,
  input  logic arst_n,
  input  logic in_valid,
  input  fma_pkg::fma_req_t req,
  input  fma_pkg::special_case_t rs1_special,
  input  fma_pkg::special_case_t rs2_special,
  input  fma_pkg::special_case_t rs3_special,
  output logic out_valid,
  output fma_pkg::fma_mul_t mul
);

  fma_pkg::fp_word_u opb;
  fma_pkg::fp_word_u opc;
  fma_pkg::special_case_t spb;
  fma_pkg::special_case_t spc;
  logic prod_sign;
  logic add_sign;
  logic [`FMA_FRAC_W:0] sig_a;
  logic [`FMA_FRAC_W:0] sig_b;
  logic [`FMA_FRAC_W:0] sig_c;
  logic nan_in;
  logic snan_in;
  logic inf_zero;
  logic prod_inf;
  logic inf_sub;
  fma_pkg::fma_mul_t next;

  always_comb begin
    opb = req.rs2;
    spb = rs2_special;
    opc = req.rs3;
    spc = rs3_special;
    prod_sign = req.rs1.fields.sign ^ req.rs2.fields.sign;
    add_sign = req.rs3.fields.sign;
    case (req.op)
      fma_pkg::FMSUB: add_sign = ~req.rs3.fields.sign;
      fma_pkg::FNMADD: begin
        prod_sign = ~(req.rs1.fields.sign ^ req.rs2.fields.sign);
        add_sign = ~req.rs3.fields.sign;
      end
      fma_pkg::FNMSUB: prod_sign = ~(req.rs1.fields.sign ^ req.rs2.fields.sign);
      fma_pkg::FMUL: begin
        opc.bits = '0;              // zero addend of the product's sign
        spc = '0;
        spc.is_zero = 1'b1;
        add_sign = prod_sign;
      end
      fma_pkg::FADD: begin
        opb.bits = '0;              // rs1 * 1.0 + rs2
        opb.fields.expo = {1'b0, {(`FMA_EXPO_W-1){1'b1}}};
        spb = '0;
        opc = req.rs2;
        spc = rs2_special;
        prod_sign = req.rs1.fields.sign;
        add_sign = req.rs2.fields.sign;
      end
      default: ;
    endcase

    sig_a = rs1_special.is_zero ? '0 : {1'b1, req.rs1.fields.frac};
    sig_b = spb.is_zero ? '0 : {1'b1, opb.fields.frac};
    sig_c = spc.is_zero ? '0 : {1'b1, opc.fields.frac};

    nan_in = rs1_special.is_snan | rs1_special.is_qnan | spb.is_snan | spb.is_qnan |
             spc.is_snan | spc.is_qnan;
    snan_in = rs1_special.is_snan | spb.is_snan | spc.is_snan;
    inf_zero = (rs1_special.is_inf & spb.is_zero) | (rs1_special.is_zero & spb.is_inf);
    prod_inf = (rs1_special.is_inf | spb.is_inf) & ~inf_zero & ~nan_in;
    inf_sub = prod_inf & spc.is_inf & (prod_sign ^ add_sign);

    next.id = req.id;
    next.prod_sign = prod_sign;
    next.prod_expo = fma_pkg::sexp_t'({2'b00, req.rs1.fields.expo}) +
                     fma_pkg::sexp_t'({2'b00, opb.fields.expo}) -
                     fma_pkg::sexp_t'((1 << (`FMA_EXPO_W - 1)) - 1);
    next.prod = sig_a * sig_b;
    next.add_sign = add_sign;
    next.add_expo = opc.fields.expo;
    next.add_sig = sig_c;
    next.special.nv = snan_in | inf_zero | inf_sub;
    next.special.nan_out = nan_in | next.special.nv;
    next.special.inf_out = ~next.special.nan_out & (prod_inf | spc.is_inf);
    next.special.inf_sign = prod_inf ? prod_sign : add_sign;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mul <= next;
    end
  end

endmodule

/* hw/fma_pkg.sv */
`include "fma_cfg.svh"

package fma_pkg;

  typedef struct packed {
    logic sign;
    logic [`FMA_EXPO_W-1:0] expo;
    logic [`FMA_FRAC_W-1:0] frac;
  } fp_fields_t;

  // one operand word, read raw or as fields
  typedef union packed {
    logic [`FMA_FLEN-1:0] bits;
    fp_fields_t fields;
  } fp_word_u;

  // exponent with room for product range and underflow
  typedef logic signed [`FMA_EXPO_W+1:0] sexp_t;

  typedef struct packed {
    logic is_inf;
    logic is_snan;
    logic is_qnan;
    logic is_zero;
  } special_case_t;

  typedef enum logic [2:0] {
    FMADD,
    FMSUB,
    FNMADD,
    FNMSUB,
    FMUL,
    FADD
  } fma_op_e;

  typedef struct packed {
    logic [`FMA_ID_W-1:0] id;
    fma_op_e op;
    fp_word_u rs1;
    fp_word_u rs2;
    fp_word_u rs3;
  } fma_req_t;

  typedef struct packed {
    logic nan_out;
    logic nv;
    logic inf_out;
    logic inf_sign;
  } fma_special_t;

  typedef struct packed {
    logic [`FMA_ID_W-1:0] id;
    logic prod_sign;
    sexp_t prod_expo;
    logic [2*`FMA_FRAC_W+1:0] prod;   // exact 48 bit product
    logic add_sign;
    logic [`FMA_EXPO_W-1:0] add_expo;
    logic [`FMA_FRAC_W:0] add_sig;
    fma_special_t special;
  } fma_mul_t;

  typedef struct packed {
    logic [`FMA_ID_W-1:0] id;
    logic sign;
    sexp_t expo;
    logic [`FMA_FRAC_W+3:0] sig;      // 24 bits then guard, round, sticky
    logic zero;
    fma_special_t special;
  } fma_sum_t;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  typedef struct packed {
    logic [`FMA_ID_W-1:0] id;
    fp_word_u data;
    fflags_t fflags;
  } fma_wb_t;

endpackage

/* hw/fma_round_stage.sv */
`include "fma_cfg.svh"

module fma_round_stage (
  input  logic clk,
  input  logic arst_n,
  input  logic in_valid,
  input  fma_pkg::fma_sum_t sum,
  output logic out_valid,
  output fma_pkg::fma_wb_t wb
);

  logic [`FMA_FRAC_W:0] mant;
  logic [`FMA_FRAC_W+1:0] mant_rnd;
  logic guard;
  logic sticky;
  logic round_up;
  logic inexact;
  fma_pkg::sexp_t expo_rnd;
  fma_pkg::fma_wb_t next;

  always_comb begin
    mant = sum.sig[`FMA_FRAC_W+3:3];
    guard = sum.sig[2];
    sticky = |sum.sig[1:0];
    round_up = guard & (sticky | mant[0]);   // ties to even
    inexact = guard | sticky;
    mant_rnd = {1'b0, mant} + (`FMA_FRAC_W + 2)'(round_up);
    // carry out leaves a zero fraction, only the exponent moves
    expo_rnd = sum.expo + fma_pkg::sexp_t'(mant_rnd[`FMA_FRAC_W+1]);

    next.id = sum.id;
    next.fflags = '0;
    next.data.fields.sign = sum.sign;
    next.data.fields.expo = expo_rnd[`FMA_EXPO_W-1:0];
    next.data.fields.frac = mant_rnd[`FMA_FRAC_W-1:0];

    if (sum.special.nan_out) begin
      next.data.bits = `FMA_CANON_NAN;
      next.fflags.nv = sum.special.nv;
    end else if (sum.special.inf_out) begin
      next.data.fields.sign = sum.special.inf_sign;
      next.data.fields.expo = '1;
      next.data.fields.frac = '0;
    end else if (sum.zero) begin
      next.data.fields.expo = '0;
      next.data.fields.frac = '0;
    end else if (expo_rnd >= fma_pkg::sexp_t'((1 << `FMA_EXPO_W) - 1)) begin
      next.data.fields.expo = '1;          // overflow to inf
      next.data.fields.frac = '0;
      next.fflags.of = 1'b1;
      next.fflags.nx = 1'b1;
    end else if (expo_rnd <= 0) begin
      next.data.fields.expo = '0;          // flush to signed zero
      next.data.fields.frac = '0;
      next.fflags.uf = 1'b1;
      next.fflags.nx = 1'b1;
    end else begin
      next.fflags.nx = inexact;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      wb <= next;
    end
  end

endmodule

/* hw/fma_unit_top.sv */
module fma_unit_top (
  input  logic clk,
  input  logic arst_n,
  input  logic issue_req,
  input  fma_pkg::fma_req_t issue_data,
  output logic issue_ack,
  output logic res_req,
  input  logic res_ack,
  output fma_pkg::fma_wb_t res_data
);

  logic take;
  logic credit;
  fma_pkg::special_case_t rs1_special;
  fma_pkg::special_case_t rs2_special;
  fma_pkg::special_case_t rs3_special;
  logic mul_valid;
  fma_pkg::fma_mul_t mul;
  logic sum_valid;
  fma_pkg::fma_sum_t sum;
  logic wb_valid;
  fma_pkg::fma_wb_t wb;

  // new request only with buffer space reserved
  assign take = issue_req & ~issue_ack & credit;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_ack <= 1'b0;
    end else if (take) begin
      issue_ack <= 1'b1;
    end else if (!issue_req) begin
      issue_ack <= 1'b0;
    end
  end

  // hidden bit is rebuilt from is_zero in the mul stage
  fp_special_case_detect rs1_detect (
    .data    (issue_data.rs1),
    .special (rs1_special),
    .hidden  ()
  );

  fp_special_case_detect rs2_detect (
    .data    (issue_data.rs2),
    .special (rs2_special),
    .hidden  ()
  );

  fp_special_case_detect rs3_detect (
    .data    (issue_data.rs3),
    .special (rs3_special),
    .hidden  ()
  );

  fma_mul_stage mul_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (take),
    .req         (issue_data),
    .rs1_special (rs1_special),
    .rs2_special (rs2_special),
    .rs3_special (rs3_special),
    .out_valid   (mul_valid),
    .mul         (mul)
  );

  fma_add_stage add_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (mul_valid),
    .mul       (mul),
    .out_valid (sum_valid),
    .sum       (sum)
  );

  fma_round_stage round_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (sum_valid),
    .sum       (sum),
    .out_valid (wb_valid),
    .wb        (wb)
  );

  fma_writeback writeback (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (wb_valid),
    .wb       (wb),
    .take     (take),
    .credit   (credit),
    .res_req  (res_req),
    .res_ack  (res_ack),
    .res_data (res_data)
  );

endmodule

/* hw/fma_writeback.sv */
`include "fma_cfg.svh"

module fma_writeback (
  input  logic clk,
  input  logic arst_n,
  input  logic in_valid,
  input  fma_pkg::fma_wb_t wb,
  input  logic take,
  output logic credit,
  output logic res_req,
  input  logic res_ack,
  output fma_pkg::fma_wb_t res_data
);

  localparam int PTR_W = $clog2(`FMA_WB_DEPTH);
  localparam int CNT_W = $clog2(`FMA_WB_DEPTH + 1);

  fma_pkg::fma_wb_t mem [`FMA_WB_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] credits;
  logic pop;

  assign pop = res_req & res_ack;
  assign credit = (credits != '0);
  assign res_data = mem[rd_ptr];   // oldest entry, held while res_req is up

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= wb;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credits <= CNT_W'(`FMA_WB_DEPTH);
      res_req <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`FMA_WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`FMA_WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(in_valid) - CNT_W'(pop);
      // credit returns only once the consumer has the entry
      credits <= credits - CNT_W'(take) + CNT_W'(pop);

      if (pop) begin
        res_req <= 1'b0;
      end else if (!res_req && !res_ack && count != '0) begin
        res_req <= 1'b1;   // wait for ack low from last transfer
      end
    end
  end

endmodule

/* hw/fp_special_case_detect.sv */
`include "fma_cfg.svh"

module fp_special_case_detect (
  input  fma_pkg::fp_word_u data,
  output fma_pkg::special_case_t special,
  output logic hidden
);

  logic expo_ones;
  logic expo_zero;
  logic frac_zero;
  logic quiet;

  assign expo_ones = &data.fields.expo;
  assign expo_zero = ~|data.fields.expo;
  assign frac_zero = ~|data.fields.frac;
  assign quiet = data.fields.frac[`FMA_FRAC_W-1];   // msb of fraction

  assign special.is_inf = expo_ones & frac_zero;
  assign special.is_snan = expo_ones & ~frac_zero & ~quiet;
  assign special.is_qnan = expo_ones & quiet;
  // subnormals count as zero, they are flushed
  assign special.is_zero = expo_zero;

  assign hidden = ~expo_zero;

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the fma testbench with verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module fma_tb -o fma_sim \
  && ./obj_dir/fma_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* sim.f */
+incdir+hw
+incdir+test
hw/fma_pkg.sv
hw/fp_special_case_detect.sv
hw/fma_mul_stage.sv
hw/fma_add_stage.sv
hw/fma_round_stage.sv
hw/fma_writeback.sv
hw/fma_unit_top.sv
test/fma_tb.sv

/* test/fma_ref.svh */
`ifndef FMA_REF_SVH
`define FMA_REF_SVH

// 32 bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic word_is_nan(input fma_pkg::fp_word_u w);
  return (w.fields.expo == 8'hff) && (w.fields.frac != '0);
endfunction

function automatic logic word_is_snan(input fma_pkg::fp_word_u w);
  return word_is_nan(w) && !w.fields.frac[`FMA_FRAC_W-1];
endfunction

function automatic logic word_is_inf(input fma_pkg::fp_word_u w);
  return (w.fields.expo == 8'hff) && (w.fields.frac == '0);
endfunction

// subnormals count as zero
function automatic logic word_is_zero(input fma_pkg::fp_word_u w);
  return w.fields.expo == '0;
endfunction

// exact a*b+c on a 2^-300 grid, one rounding at the end
function automatic fma_pkg::fma_wb_t fma_ref(input fma_pkg::fma_req_t req);
  fma_pkg::fma_wb_t res;
  fma_pkg::fp_word_u x;
  fma_pkg::fp_word_u y;
  fma_pkg::fp_word_u z;
  logic ps;
  logic zs;
  logic sign;
  logic any_nan;
  logic inf_zero;
  logic prod_inf;
  logic inf_inf;
  logic [23:0] mx;
  logic [23:0] my;
  logic [23:0] mz;
  logic [47:0] p;
  logic [599:0] pint;
  logic [599:0] cint;
  logic [599:0] mag;
  logic [24:0] mant;
  logic guard;
  logic sticky;
  logic inexact;
  int sh;
  int h;
  int e;
  x = req.rs1;
  y = req.rs2;
  z = req.rs3;
  ps = x.fields.sign ^ y.fields.sign;
  zs = z.fields.sign;
  case (req.op)
    fma_pkg::FMSUB: zs = ~zs;
    fma_pkg::FNMADD: begin
      ps = ~ps;
      zs = ~zs;
    end
    fma_pkg::FNMSUB: ps = ~ps;
    fma_pkg::FMUL: begin
      z.bits = '0;   // zero of the product's sign
      zs = ps;
    end
    fma_pkg::FADD: begin
      y.bits = 32'h3f800000;
      z = req.rs2;
      ps = x.fields.sign;
      zs = z.fields.sign;
    end
    default: ;
  endcase
  res.id = req.id;
  res.fflags = '0;
  res.data.bits = '0;

  any_nan = word_is_nan(x) | word_is_nan(y) | word_is_nan(z);
  inf_zero = (word_is_inf(x) & word_is_zero(y)) | (word_is_zero(x) & word_is_inf(y));
  prod_inf = (word_is_inf(x) | word_is_inf(y)) & ~any_nan & ~inf_zero;
  inf_inf = prod_inf & word_is_inf(z) & (ps != zs);
  if (any_nan | inf_zero | inf_inf) begin
    res.data.bits = `FMA_CANON_NAN;
    res.fflags.nv = word_is_snan(x) | word_is_snan(y) | word_is_snan(z) | inf_zero | inf_inf;
    return res;
  end
  if (prod_inf | word_is_inf(z)) begin
    res.data.fields.sign = prod_inf ? ps : zs;
    res.data.fields.expo = '1;
    return res;
  end

  mx = word_is_zero(x) ? 24'd0 : {1'b1, x.fields.frac};
  my = word_is_zero(y) ? 24'd0 : {1'b1, y.fields.frac};
  mz = word_is_zero(z) ? 24'd0 : {1'b1, z.fields.frac};
  p = mx * my;
  sh = int'(x.fields.expo) + int'(y.fields.expo);
  pint = {552'd0, p} << sh;
  sh = int'(z.fields.expo) + 150;
  cint = {576'd0, mz} << sh;
  if (ps == zs) begin
    mag = pint + cint;
    sign = ps;
  end else if (pint >= cint) begin
    mag = pint - cint;
    sign = ps;
  end else begin
    mag = cint - pint;
    sign = zs;
  end
  if (mag == '0) begin
    res.data.fields.sign = (ps == zs) & ps;   // cancellation gives +0
    return res;
  end

  h = 0;
  for (int i = 0; i < 600; i++) begin
    if (mag[i]) begin
      h = i;
    end
  end
  e = h - 173;
  inexact = 1'b0;
  mant = '0;
  if (h >= 24) begin
    mant = 25'(mag >> (h - 23));
    guard = mag[h-24];
    sticky = (mag & ((600'd1 << (h - 24)) - 600'd1)) != '0;
    inexact = guard | sticky;
    if (guard && (sticky || mant[0])) begin
      mant = mant + 25'd1;
    end
    if (mant[24]) begin
      mant = mant >> 1;
      e = e + 1;
    end
  end
  res.data.fields.sign = sign;
  if (e >= 255) begin
    res.data.fields.expo = '1;
    res.fflags.of = 1'b1;
    res.fflags.nx = 1'b1;
  end else if (e <= 0) begin
    res.fflags.uf = 1'b1;          // flushed to signed zero
    res.fflags.nx = 1'b1;
  end else begin
    res.data.fields.expo = e[7:0];
    res.data.fields.frac = mant[22:0];
    res.fflags.nx = inexact;
  end
  return res;
endfunction

`endif

/* test/fma_tb.sv */
`include "fma_cfg.svh"

module fma_tb;

  `include "fma_ref.svh"

  localparam int N_DIRECTED = 30;
  localparam int N_MULADD = 40;
  localparam int N_BP = 32;
  localparam int N_RAND = 400;
  localparam int TOTAL_REQS = N_DIRECTED + N_MULADD + N_BP + N_RAND;
  localparam int CYCLE_LIMIT = 8 * TOTAL_REQS * 8 + 200;

  logic clk;
  logic arst_n;
  logic issue_req;
  fma_pkg::fma_req_t issue_data;
  logic issue_ack;
  logic res_req;
  logic res_ack;
  fma_pkg::fma_wb_t res_data;

  fma_pkg::fma_wb_t exp_q[$];
  fma_pkg::fma_req_t req_q[$];
  logic [31:0] stim_state = 32'h1026;
  logic [31:0] delay_state = 32'h1026;
  logic [`FMA_ID_W-1:0] next_id = '0;
  int hold_max = 0;
  int outstanding = 0;
  int cycles = 0;
  int data_errs = 0;
  int flag_errs = 0;
  int id_errs = 0;
  int other_errs = 0;

  fma_unit_top UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .issue_req  (issue_req),
    .issue_data (issue_data),
    .issue_ack  (issue_ack),
    .res_req    (res_req),
    .res_ack    (res_ack),
    .res_data   (res_data)
  );

  always #10 clk = ~clk;

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_next(state);
      bits = {bits[30:0], state[0]};
    end
  endtask

  // any_class adds zeros, subnormals, infs, nans and full exponent range
  task automatic random_operand(input logic any_class, output logic [31:0] w);
    logic [31:0] cls;
    logic [31:0] sign;
    logic [31:0] expo;
    logic [31:0] frac;
    take_bits(stim_state, 4, cls);
    take_bits(stim_state, 1, sign);
    take_bits(stim_state, 8, expo);
    take_bits(stim_state, 23, frac);
    if (!any_class || cls > 3) begin
      expo = 32'd112 + expo[4:0];   // near one
    end else if (cls == 0) begin
      expo = 0;
    end else if (cls == 1) begin
      expo = 255;
      frac = 0;
    end else if (cls == 2) begin
      expo = 255;
      frac = frac | 32'd1;
    end else if (expo == 0 || expo == 255) begin
      expo = 1;
    end
    w = {sign[0], expo[7:0], frac[22:0]};
  endtask

  task automatic issue(input fma_pkg::fma_op_e op, input logic [31:0] a,
                       input logic [31:0] b, input logic [31:0] c);
    fma_pkg::fma_req_t req;
    req.id = next_id;
    req.op = op;
    req.rs1.bits = a;
    req.rs2.bits = b;
    req.rs3.bits = c;
    next_id = next_id + 1'b1;
    exp_q.push_back(fma_ref(req));
    req_q.push_back(req);
    issue_req <= 1'b1;
    issue_data <= req;
    do @(posedge clk); while (!issue_ack);
    outstanding++;
    if (outstanding > `FMA_WB_DEPTH) begin
      $display("request %0d accepted with %0d results already outstanding", req.id,
               outstanding - 1);
      other_errs++;
    end
    issue_req <= 1'b0;
    do @(posedge clk); while (issue_ack);
  endtask

  task automatic random_request();
    logic [31:0] bits;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    take_bits(stim_state, 3, bits);
    random_operand(1'b1, a);
    random_operand(1'b1, b);
    random_operand(1'b1, c);
    issue(fma_pkg::fma_op_e'(bits % 6), a, b, c);
  endtask

  task automatic check_data(input fma_pkg::fp_word_u got, input fma_pkg::fp_word_u exp,
                            input string ctx);
    if (got.bits !== exp.bits) begin
      $display("Fail at %0t: result %h, expected %h for %s", $time, got.bits, exp.bits, ctx);
      data_errs++;
    end
  endtask

  task automatic check_flags(input fma_pkg::fflags_t got, input fma_pkg::fflags_t exp,
                             input string ctx);
    if (got !== exp) begin
      $display("Fail at %0t: fflags %b, expected %b for %s", $time, got, exp, ctx);
      flag_errs++;
    end
  endtask

  task automatic check_id(input logic [`FMA_ID_W-1:0] got, input logic [`FMA_ID_W-1:0] exp,
                          input string ctx);
    if (got !== exp) begin
      $display("Fail at %0t: id %0d, expected %0d for %s", $time, got, exp, ctx);
      id_errs++;
    end
  endtask

  // consumer side, holds off res_ack for a random stretch
  initial begin
    fma_pkg::fma_wb_t got;
    fma_pkg::fma_wb_t exp;
    fma_pkg::fma_req_t req;
    logic [31:0] bits;
    int hold;
    string ctx;
    res_ack = 1'b0;
    forever begin
      @(posedge clk);
      if (res_req) begin
        take_bits(delay_state, 6, bits);
        hold = (hold_max == 0) ? 0 : int'(bits % (hold_max + 1));
        repeat (hold) @(posedge clk);
        got = res_data;
        if (exp_q.size() == 0) begin
          $display("result with id %0d arrived but no request was outstanding", got.id);
          other_errs++;
        end else begin
          exp = exp_q.pop_front();
          req = req_q.pop_front();
          ctx = $sformatf("id %0d %s %h %h %h", req.id, req.op.name(), req.rs1.bits,
                          req.rs2.bits, req.rs3.bits);
          check_id(got.id, exp.id, ctx);
          check_data(got.data, exp.data, ctx);
          check_flags(got.fflags, exp.fflags, ctx);
        end
        res_ack <= 1'b1;
        do @(posedge clk); while (res_req);
        res_ack <= 1'b0;
        outstanding--;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d results never arrived", cycles, exp_q.size());
      $display("errors: data %0d, flags %0d, id %0d, other %0d", data_errs, flag_errs,
               id_errs, other_errs + 1);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    clk = 1'b0;
    arst_n = 1'b0;
    issue_req = 1'b0;
    issue_data = '0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // normal numbers, cancellation to +0
    issue(fma_pkg::FMADD, 32'h3fc00000, 32'h40000000, 32'h3e800000);
    issue(fma_pkg::FMSUB, 32'h40400000, 32'h40400000, 32'h41100000);
    issue(fma_pkg::FNMADD, 32'h3dcccccd, 32'h41200000, 32'h3f800000);
    issue(fma_pkg::FNMSUB, 32'h3fc00000, 32'h40000000, 32'h40400000);
    issue(fma_pkg::FMADD, 32'h3f800001, 32'h3f7fffff, 32'hbf800000);
    issue(fma_pkg::FMSUB, 32'h3dcccccd, 32'h3dcccccd, 32'h3c23d70a);
    issue(fma_pkg::FNMADD, 32'hbf800000, 32'h3f800000, 32'hbf800000);
    issue(fma_pkg::FNMSUB, 32'h3eaaaaab, 32'h40400000, 32'h3f800000);

    for (int i = 0; i < N_MULADD; i++) begin
      random_operand(1'b0, a);
      random_operand(1'b0, b);
      if (i % 2 == 0) begin
        issue(fma_pkg::FMUL, a, b, 32'h0);
      end else begin
        issue(fma_pkg::FADD, a, b, 32'h0);
      end
    end

    // nan, inf*0, inf-inf and signed infinities
    issue(fma_pkg::FMADD, 32'h7f800001, 32'h3f800000, 32'h3f800000);
    issue(fma_pkg::FMADD, 32'h3f800000, 32'h7fc12345, 32'h3f800000);
    issue(fma_pkg::FMSUB, 32'h3f800000, 32'h3f800000, 32'hffc00000);
    issue(fma_pkg::FMADD, 32'h7f800000, 32'h00000000, 32'h3f800000);
    issue(fma_pkg::FMADD, 32'h80000000, 32'hff800000, 32'h7fc00000);
    issue(fma_pkg::FMADD, 32'h7f800000, 32'h3f800000, 32'hff800000);
    issue(fma_pkg::FMSUB, 32'h7f800000, 32'h3f800000, 32'h7f800000);
    issue(fma_pkg::FMADD, 32'hff800000, 32'h40000000, 32'h3f800000);
    issue(fma_pkg::FNMADD, 32'h7f800000, 32'h40000000, 32'h3f800000);
    issue(fma_pkg::FMADD, 32'h3f800000, 32'h3f800000, 32'h7f800000);
    issue(fma_pkg::FMUL, 32'h7f800000, 32'hbf800000, 32'h0);
    issue(fma_pkg::FADD, 32'h7f800000, 32'h7f800000, 32'h0);
    issue(fma_pkg::FADD, 32'h7f800000, 32'hff800000, 32'h0);

    // overflow, underflow, subnormal inputs
    issue(fma_pkg::FMUL, 32'h7f000000, 32'h7f000000, 32'h0);
    issue(fma_pkg::FMADD, 32'h7f7fffff, 32'h40000000, 32'h7f7fffff);
    issue(fma_pkg::FADD, 32'h7f7fffff, 32'h7f7fffff, 32'h0);
    issue(fma_pkg::FNMADD, 32'h7f000000, 32'h40000000, 32'h0);
    issue(fma_pkg::FMUL, 32'h00800000, 32'h3f000000, 32'h0);
    issue(fma_pkg::FMUL, 32'h80800000, 32'h00800000, 32'h0);
    issue(fma_pkg::FMADD, 32'h00400000, 32'h3f800000, 32'h3f800000);
    issue(fma_pkg::FMADD, 32'h3f800000, 32'h00000001, 32'h80000000);
    issue(fma_pkg::FADD, 32'h00800001, 32'h80800000, 32'h0);

    hold_max = 63;   // long res_ack stalls, buffer fills
    repeat (N_BP) random_request();
    hold_max = 3;
    repeat (N_RAND) random_request();

    hold_max = 0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);
    $display("errors: data %0d, flags %0d, id %0d, other %0d", data_errs, flag_errs, id_errs,
             other_errs);
    if (data_errs + flag_errs + id_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
